// ==== zx_host.f ====
+incdir+.
zx_pkg.sv
zx_clocking.sv
zx_hotkeys.sv
zx_io_bus.sv
zx_paging.sv
zx_ula_port.sv
zx_host.sv
tb_zx_host.sv

// ==== run.sh ====
#!/bin/sh
# Builds the zx_host testbench with Verilator and runs it; a failing run exits non-zero
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_zx_host -f zx_host.f -o tb_zx_host &&
./obj_dir/tb_zx_host || exit 1

// ==== tb_zx_bus.svh ====
// Bus-cycle, key-press and random byte helpers that the zx_host testbench includes in its body
`ifndef TB_ZX_BUS_SVH
`define TB_ZX_BUS_SVH

logic [31:0] lcg_state = 32'hbf606a44;

// LCG step returning its best mixed top byte
function automatic logic [7:0] rand_byte();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state[31:24];
endfunction

// Releases all strobes for one cycle
task automatic bus_idle();
	n_mreq = 1'b1;
	n_iorq = 1'b1;
	n_rd   = 1'b1;
	n_wr   = 1'b1;
	@(negedge clk_sys);
endtask

// I/O write held for two cycles
task automatic io_write(input logic [15:0] a, input logic [7:0] d);
	addr     = a;
	bus_dout = d;
	n_iorq   = 1'b0;
	n_wr     = 1'b0;
	repeat (2) @(negedge clk_sys);
	bus_idle();
endtask

// Opens an I/O or memory cycle for one cycle; caller checks, then calls bus_idle
task automatic bus_start(input logic [15:0] a, input logic io, input logic write);
	addr   = a;
	n_iorq = ~io;
	n_mreq = io;
	n_wr   = ~write;
	n_rd   = write;
	@(negedge clk_sys);
endtask

task automatic press_key(input int idx);
	fn_keys[idx] = 1'b1;
	repeat (2) @(negedge clk_sys);
	fn_keys[idx] = 1'b0;
	repeat (2) @(negedge clk_sys);
endtask

task automatic hold_reset_button();
	reset_button = 1'b1;
	repeat (3) @(negedge clk_sys);
	reset_button = 1'b0;
	repeat (3) @(negedge clk_sys);
endtask

`endif

// ==== tb_zx_host.sv ====
// Testbench for zx_host; drives bus cycles and hotkeys, checks paging, ULA, enables and resets
`timescale 1ns/1ps
`default_nettype none

module tb_zx_host;

	localparam int DIV_W          = 6;
	localparam int TIMEOUT_CYCLES = 20000;     // Tests need about 2500 cycles

	logic             clk_sys;
	logic             reset;
	logic [15:0]      addr;
	logic [7:0]       bus_dout;
	logic             n_m1;
	logic             n_mreq;
	logic             n_iorq;
	logic             n_rd;
	logic             n_wr;
	logic [7:0]       ram_dout;
	logic [4:0]       key_data;
	logic             ear_in;
	logic [11:1]      fn_keys;
	logic [2:0]       mod_keys;
	logic             reset_button;
	zx_pkg::machine_e machine_sel;
	logic [7:0]       cpu_din;
	logic [17:0]      ram_addr;
	logic             mem_rd;
	logic             mem_wr;
	logic             screen_page;
	logic [2:0]       border_color;
	logic             ear_out;
	logic             mic_out;
	logic             ce_cpu_p;
	logic             ce_cpu_n;
	logic             ce_psg;
	logic             cpu_reset;
	logic             nmi;
	int               cycle_count = 0;

	`include "tb_zx_bus.svh"

	zx_host #(
		.DIV_W(DIV_W)
	) u_zx_host (
		.clk_sys(clk_sys), .reset(reset), .addr(addr), .bus_dout(bus_dout),
		.n_m1(n_m1), .n_mreq(n_mreq), .n_iorq(n_iorq), .n_rd(n_rd), .n_wr(n_wr),
		.ram_dout(ram_dout), .key_data(key_data), .ear_in(ear_in), .fn_keys(fn_keys),
		.mod_keys(mod_keys), .reset_button(reset_button), .machine_sel(machine_sel),
		.cpu_din(cpu_din), .ram_addr(ram_addr), .mem_rd(mem_rd), .mem_wr(mem_wr),
		.screen_page(screen_page), .border_color(border_color), .ear_out(ear_out),
		.mic_out(mic_out), .ce_cpu_p(ce_cpu_p), .ce_cpu_n(ce_cpu_n), .ce_psg(ce_psg),
		.cpu_reset(cpu_reset), .nmi(nmi)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("*** FAILED ***");
			$fatal(1);
		end
	end

	// ========================================
	// Checks
	// ========================================
	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp) else begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			$display("*** FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			$display("%s", what);
			$display("*** FAILED ***");
			$fatal(1);
		end
	endtask

	// CPU address to bank plus offset
	task automatic check_bank(input logic [15:0] a, input logic [3:0] bank);
		addr = a;
		@(negedge clk_sys);
		check_value("ram_addr", 32'(ram_addr), 32'({bank, a[13:0]}));
	endtask

	function automatic logic enable_level(input int sel);
		case (sel)
			0:       return ce_cpu_p;
			1:       return ce_cpu_n;
			default: return ce_psg;
		endcase
	endfunction

	// Cycles up to the next pulse of the chosen enable
	task automatic wait_enable(input int sel, input int limit, output int cycles);
		cycles = 0;
		do begin
			@(negedge clk_sys);
			cycles++;
		end while (!enable_level(sel) && cycles < limit);
		check_true(enable_level(sel), "A clock enable did not pulse within the expected time");
	endtask

	initial begin
		logic [7:0]  data;
		logic [7:0]  locked;
		logic [7:0]  r;
		logic [13:0] offset;
		int          cycles;
		int          period;
		int          p_to_n;
		int          speed;

		reset        = 1'b1;
		addr         = 16'h0000;
		bus_dout     = 8'h00;
		n_m1         = 1'b1;
		n_mreq       = 1'b1;
		n_iorq       = 1'b1;
		n_rd         = 1'b1;
		n_wr         = 1'b1;
		ram_dout     = 8'h00;
		key_data     = 5'h1F;                    // No key pressed
		ear_in       = 1'b0;
		fn_keys      = '0;
		mod_keys     = 3'b000;
		reset_button = 1'b0;
		machine_sel  = zx_pkg::MACHINE_128;
		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		// ======== Reset state
		repeat (3) begin
			@(negedge clk_sys);
			check_value("ce_cpu_p", 32'(ce_cpu_p), 32'h0);
			check_value("mem_wr", 32'(mem_wr), 32'h0);
		end
		check_value("cpu_reset", 32'(cpu_reset), 32'h0);
		check_value("nmi", 32'(nmi), 32'h0);
		check_value("ear_out", 32'(ear_out), 32'h0);
		check_value("mic_out", 32'(mic_out), 32'h0);
		check_value("screen_page", 32'(screen_page), 32'h0);
		check_bank(16'h0000, zx_pkg::BANK_ROM0);
		check_bank(16'hC000, 4'd0);

		// ======== 7FFD paging, lock and 48 mode
		r      = rand_byte();
		offset = {r[5:0], rand_byte()};
		data   = rand_byte() & 8'h1F;            // Lock bit clear
		io_write(16'h7FFD, data);
		check_value("screen_page", 32'(screen_page), 32'(data[3]));
		check_bank({2'b11, offset}, {1'b0, data[2:0]});
		check_bank({2'b00, offset}, data[4] ? zx_pkg::BANK_ROM1 : zx_pkg::BANK_ROM0);
		bus_start({2'b00, offset}, 1'b0, 1'b1);
		check_value("mem_wr", 32'(mem_wr), 32'h0);  // ROM area
		bus_idle();
		bus_start({2'b01, offset}, 1'b0, 1'b1);
		check_value("mem_wr", 32'(mem_wr), 32'h1);
		bus_idle();
		locked = rand_byte() | 8'h20;
		io_write(16'h7FFD, locked);
		check_bank(16'hC000, {1'b0, locked[2:0]});
		io_write(16'h7FFD, ~locked);
		check_bank({2'b11, offset}, {1'b0, locked[2:0]});
		check_bank(16'h0000, locked[4] ? zx_pkg::BANK_ROM1 : zx_pkg::BANK_ROM0);
		check_value("screen_page", 32'(screen_page), 32'(locked[3]));
		machine_sel = zx_pkg::MACHINE_48;
		hold_reset_button();
		io_write(16'h7FFD, 8'h17);
		check_bank(16'hC000, 4'd0);
		check_bank(16'h0000, zx_pkg::BANK_ROM1);
		check_value("screen_page", 32'(screen_page), 32'h0);
		machine_sel = zx_pkg::MACHINE_128;
		hold_reset_button();
		check_bank(16'h0000, zx_pkg::BANK_ROM0);

		// ======== ULA port
		data = rand_byte();
		io_write({rand_byte(), 8'hFE}, data);
		check_value("border_color", 32'(border_color), 32'(data[2:0]));
		check_value("ear_out", 32'(ear_out), 32'(data[4]));
		check_value("mic_out", 32'(mic_out), 32'(data[3]));
		data     = rand_byte();
		key_data = data[4:0];
		ear_in   = data[7];
		bus_start(16'h00FE, 1'b1, 1'b0);
		check_value("cpu_din", 32'(cpu_din), 32'({1'b1, ear_in, 1'b1, key_data}));
		bus_idle();
		bus_start(16'h00FF, 1'b1, 1'b0);
		check_value("cpu_din", 32'(cpu_din), 32'hFF);
		bus_idle();
		ram_dout = rand_byte();
		bus_start({2'b10, offset}, 1'b0, 1'b0);
		check_value("cpu_din", 32'(cpu_din), 32'(ram_dout));
		check_value("mem_rd", 32'(mem_rd), 32'h1);
		bus_idle();

		// ======== Turbo keys F5 to F8 and back to F4
		for (int i = 1; i <= 5; i++) begin
			speed  = i % 5;
			period = 32 >> speed;
			press_key(4 + speed);
			repeat (40) @(negedge clk_sys);      // Old speed's last slot has passed
			wait_enable(0, 200, cycles);
			for (int k = 0; k < 3; k++) begin
				wait_enable(1, period + 2, p_to_n);
				check_value("ce_cpu_n offset", 32'(p_to_n), 32'(period / 2));
				wait_enable(0, period + 2, cycles);
				check_value("ce_cpu_p period", 32'(p_to_n + cycles), 32'(period));
			end
		end

		// ======== PSG enable and pause
		wait_enable(2, 70, cycles);
		wait_enable(2, 70, cycles);
		check_value("ce_psg period", 32'(cycles), 32'd64);
		press_key(9);
		repeat (40) @(negedge clk_sys);
		repeat (200) begin
			@(negedge clk_sys);
			check_true(!ce_psg && !ce_cpu_p, "An enable pulsed while the CPU was paused");
		end
		press_key(9);
		wait_enable(2, 70, cycles);
		wait_enable(0, 100, cycles);

		// ======== NMI and reset hotkeys
		fn_keys[11] = 1'b1;
		repeat (2) @(negedge clk_sys);
		check_value("nmi", 32'(nmi), 32'h1);
		check_value("cpu_reset", 32'(cpu_reset), 32'h0);
		fn_keys[11] = 1'b0;
		repeat (2) @(negedge clk_sys);
		check_value("nmi", 32'(nmi), 32'h0);
		mod_keys    = 3'b100;                    // Warm reset code
		fn_keys[11] = 1'b1;
		repeat (2) @(negedge clk_sys);
		check_value("cpu_reset", 32'(cpu_reset), 32'h1);
		check_value("nmi", 32'(nmi), 32'h0);
		fn_keys[11] = 1'b0;
		mod_keys    = 3'b000;
		repeat (2) @(negedge clk_sys);
		check_value("cpu_reset", 32'(cpu_reset), 32'h0);
		fn_keys[10] = 1'b1;
		repeat (2) @(negedge clk_sys);
		check_value("cpu_reset", 32'(cpu_reset), 32'h1);
		check_bank(16'h0123, zx_pkg::BANK_ROM1);
		fn_keys[10] = 1'b0;
		repeat (2) @(negedge clk_sys);
		check_value("cpu_reset", 32'(cpu_reset), 32'h0);

		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== zx_host.sv ====
// Top level of the Spectrum 128 host glue; connects clocking, hotkeys, bus, paging and ULA
`timescale 1ns/1ps
`default_nettype none

module zx_host #(
	parameter int DIV_W = 6
) (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  logic [zx_pkg::ADDR_W-1:0]      addr,
	input  logic [zx_pkg::DATA_W-1:0]      bus_dout,
	input  logic                           n_m1,
	input  logic                           n_mreq,
	input  logic                           n_iorq,
	input  logic                           n_rd,
	input  logic                           n_wr,
	input  logic [zx_pkg::DATA_W-1:0]      ram_dout,
	input  logic [4:0]                     key_data,
	input  logic                           ear_in,
	input  logic [zx_pkg::FN_W:1]          fn_keys,
	input  logic [2:0]                     mod_keys,
	input  logic                           reset_button,
	input  zx_pkg::machine_e               machine_sel,
	output logic [zx_pkg::DATA_W-1:0]      cpu_din,
	output logic [zx_pkg::BANK_ADDR_W-1:0] ram_addr,
	output logic                           mem_rd,
	output logic                           mem_wr,
	output logic                           screen_page,
	output logic [2:0]                     border_color,
	output logic                           ear_out,
	output logic                           mic_out,
	output logic                           ce_cpu_p,
	output logic                           ce_cpu_n,
	output logic                           ce_psg,
	output logic                           cpu_reset,
	output logic                           nmi
);

	zx_pkg::turbo_e              turbo_key;
	logic                        pause;
	logic                        io_wr_pulse;
	logic [zx_pkg::DATA_W-1:0]   ula_read_data;

	// ========================================
	// Clocks and hotkeys
	// ========================================
	zx_clocking #(
		.DIV_W(DIV_W)
	) u_clocking (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu_reset (cpu_reset),
		.turbo_key (turbo_key),
		.pause     (pause),
		.ce_cpu_p  (ce_cpu_p),
		.ce_cpu_n  (ce_cpu_n),
		.ce_psg    (ce_psg)
	);

	zx_hotkeys u_hotkeys (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.reset_button (reset_button),
		.fn_keys      (fn_keys),
		.mod_keys     (mod_keys),
		.turbo_key    (turbo_key),
		.pause        (pause),
		.cpu_reset    (cpu_reset),
		.nmi          (nmi)
	);

	// ========================================
	// CPU bus side
	// ========================================
	zx_io_bus u_io_bus (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.n_m1          (n_m1),
		.n_mreq        (n_mreq),
		.n_iorq        (n_iorq),
		.n_rd          (n_rd),
		.n_wr          (n_wr),
		.addr          (addr),
		.ram_dout      (ram_dout),
		.ula_read_data (ula_read_data),
		.io_wr_pulse   (io_wr_pulse),
		.io_rd_pulse   (),                     // No read-triggered ports in this build
		.mem_rd        (mem_rd),
		.mem_wr        (mem_wr),
		.cpu_din       (cpu_din)
	);

	zx_paging u_paging (
		.clk_sys     (clk_sys),
		.cpu_reset   (cpu_reset),
		.fn10        (fn_keys[10]),
		.machine_sel (machine_sel),
		.io_wr_pulse (io_wr_pulse),
		.addr        (addr),
		.bus_dout    (bus_dout),
		.ram_addr    (ram_addr),
		.screen_page (screen_page)
	);

	zx_ula_port u_ula_port (
		.clk_sys       (clk_sys),
		.cpu_reset     (cpu_reset),
		.io_wr_pulse   (io_wr_pulse),
		.addr          (addr),
		.bus_dout      (bus_dout),
		.key_data      (key_data),
		.ear_in        (ear_in),
		.border_color  (border_color),
		.ear_out       (ear_out),
		.mic_out       (mic_out),
		.ula_read_data (ula_read_data)
	);

endmodule

`default_nettype wire

// ==== zx_ula_port.sv ====
// ULA port FE latching border, EAR and MIC on write and returning keys and tape level on read
`timescale 1ns/1ps
`default_nettype none

module zx_ula_port (
	input  logic                      clk_sys,
	input  logic                      cpu_reset,
	input  logic                      io_wr_pulse,
	input  logic [zx_pkg::ADDR_W-1:0] addr,
	input  logic [zx_pkg::DATA_W-1:0] bus_dout,
	input  logic [4:0]                key_data,      // Active low key columns
	input  logic                      ear_in,
	output logic [2:0]                border_color,
	output logic                      ear_out,
	output logic                      mic_out,
	output logic [zx_pkg::DATA_W-1:0] ula_read_data
);

	logic ula_we;

	assign ula_we = io_wr_pulse & ~addr[0];

	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			ear_out <= 1'b0;
			mic_out <= 1'b0;
		end else if (ula_we) begin
			border_color <= bus_dout[2:0];
			ear_out      <= bus_dout[4];
			mic_out      <= bus_dout[3];
		end
	end

	assign ula_read_data = {1'b1, ear_in, 1'b1, key_data};

endmodule

`default_nettype wire

// ==== zx_paging.sv ====
// 128K paging register at 7FFD with machine mode and the 16 KB bank address map
`timescale 1ns/1ps
`default_nettype none

module zx_paging (
	input  logic                           clk_sys,
	input  logic                           cpu_reset,
	input  logic                           fn10,         // F10 held selects the 48 ROM
	input  zx_pkg::machine_e               machine_sel,
	input  logic                           io_wr_pulse,
	input  logic [zx_pkg::ADDR_W-1:0]      addr,
	input  logic [zx_pkg::DATA_W-1:0]      bus_dout,
	output logic [zx_pkg::BANK_ADDR_W-1:0] ram_addr,
	output logic                           screen_page
);

	zx_pkg::machine_e            machine;
	logic [5:0]                  page_reg;
	logic                        zx48;
	logic                        page_disable;
	logic                        page_write;
	logic [zx_pkg::BANK_W-1:0]   bank;

	assign zx48         = (machine == zx_pkg::MACHINE_48);
	assign page_disable = zx48 | page_reg[5];   // 48 mode or lock bit
	assign page_write   = ~addr[15] & ~addr[1] & ~page_disable;

	// ========================================
	// Page register
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			machine     <= machine_sel;
			page_reg    <= '0;
			page_reg[4] <= fn10;
		end else if (io_wr_pulse && page_write) begin
			page_reg <= bus_dout[5:0];
		end
	end

	assign screen_page = page_reg[3];

	// ========================================
	// Bank map
	// ========================================
	always_comb begin
		case (addr[15:14])
			2'd0: begin
				if (zx48 || page_reg[4])
					bank = zx_pkg::BANK_ROM1;
				else
					bank = zx_pkg::BANK_ROM0;
			end
			2'd1:    bank = zx_pkg::BANK_SCREEN;
			2'd2:    bank = zx_pkg::BANK_MID;
			default: bank = {1'b0, page_reg[2:0]}; // Paged RAM 0..7
		endcase
	end

	assign ram_addr = {bank, addr[zx_pkg::OFFSET_W-1:0]};

endmodule

`default_nettype wire

// ==== zx_io_bus.sv ====
// Z80 bus strobe decoding with I/O edge pulses, memory enables and the CPU data-in mux
`timescale 1ns/1ps
`default_nettype none

module zx_io_bus (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      n_m1,
	input  logic                      n_mreq,
	input  logic                      n_iorq,
	input  logic                      n_rd,
	input  logic                      n_wr,
	input  logic [zx_pkg::ADDR_W-1:0] addr,
	input  logic [zx_pkg::DATA_W-1:0] ram_dout,
	input  logic [zx_pkg::DATA_W-1:0] ula_read_data,
	output logic                      io_wr_pulse,
	output logic                      io_rd_pulse,
	output logic                      mem_rd,
	output logic                      mem_wr,
	output logic [zx_pkg::DATA_W-1:0] cpu_din
);

	logic io_wr;
	logic io_rd;
	logic old_wr;
	logic old_rd;

	// Interrupt acknowledge has n_m1 low and is no I/O cycle
	assign io_wr = ~n_iorq & ~n_wr & n_m1;
	assign io_rd = ~n_iorq & ~n_rd & n_m1;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_wr <= 1'b0;
			old_rd <= 1'b0;
		end else begin
			old_wr <= io_wr;
			old_rd <= io_rd;
		end
	end

	assign io_wr_pulse = io_wr & ~old_wr;
	assign io_rd_pulse = io_rd & ~old_rd;

	assign mem_rd = ~n_mreq & ~n_rd;
	assign mem_wr = ~n_mreq & ~n_wr & (addr[15] | addr[14]); // ROM area is read-only

	always_comb begin
		if (!n_mreq)
			cpu_din = ram_dout;
		else if (io_rd && !addr[0])
			cpu_din = ula_read_data;           // Port FE and all other even ports
		else
			cpu_din = 8'hFF;                   // Floating bus
	end

endmodule

`default_nettype wire

// ==== zx_hotkeys.sv ====
// Function-key handling for turbo, pause, CPU reset and NMI requests
`timescale 1ns/1ps
`default_nettype none

module zx_hotkeys (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  reset_button,
	input  logic [zx_pkg::FN_W:1] fn_keys,      // F1..F11, high while held
	input  logic [2:0]            mod_keys,
	output zx_pkg::turbo_e        turbo_key,
	output logic                  pause,
	output logic                  cpu_reset,
	output logic                  nmi
);

	logic [9:4] old_fn;
	logic [9:4] fn_rise;
	logic       old_f11;
	logic       no_mod;

	assign fn_rise = fn_keys[9:4] & ~old_fn;
	assign no_mod  = (mod_keys == 3'b000);

	// Speed and pause selection
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_fn    <= '0;
			turbo_key <= zx_pkg::TURBO_3M5;
			pause     <= 1'b0;
		end else begin
			old_fn <= fn_keys[9:4];
			if (no_mod) begin
				if (fn_rise[4]) turbo_key <= zx_pkg::TURBO_3M5;
				if (fn_rise[5]) turbo_key <= zx_pkg::TURBO_7M;
				if (fn_rise[6]) turbo_key <= zx_pkg::TURBO_14M;
				if (fn_rise[7]) turbo_key <= zx_pkg::TURBO_28M;
				if (fn_rise[8]) turbo_key <= zx_pkg::TURBO_56M;
				if (fn_rise[9]) pause <= ~pause;
			end
			if (cpu_reset)
				pause <= 1'b0;                 // A reset always resumes
		end
	end

	// Reset sources and NMI
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_f11   <= 1'b0;
			cpu_reset <= 1'b1;
			nmi       <= 1'b0;
		end else begin
			old_f11   <= fn_keys[11];
			// Warm reset is F11 with mod code 2
			cpu_reset <= reset_button | fn_keys[10] | (fn_keys[11] & (mod_keys[2:1] == 2'd2));
			if (cpu_reset || !fn_keys[11])
				nmi <= 1'b0;
			else if (!old_f11 && fn_keys[11] && mod_keys[2:1] == 2'd0)
				nmi <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== zx_clocking.sv ====
// Clock enables for the CPU and PSG, with turbo switching and pause; driven from clk_sys
`timescale 1ns/1ps
`default_nettype none

module zx_clocking #(
	parameter int DIV_W = 6                     // At least 5 bits for the turbo masks
) (
	input  logic           clk_sys,
	input  logic           reset,
	input  logic           cpu_reset,
	input  zx_pkg::turbo_e turbo_key,
	input  logic           pause,
	output logic           ce_cpu_p,
	output logic           ce_cpu_n,
	output logic           ce_psg
);

	logic [DIV_W-1:0] counter;
	logic [4:0]       mask;
	logic [4:0]       phase;
	logic             tick_p;                  // Ungated CPU phases
	logic             tick_n;
	zx_pkg::turbo_e   turbo;                   // Speed in use
	logic             cpu_en;
	logic [1:0]       timeout;                 // Counts ce_cpu_n slots before re-enable

	function automatic logic [4:0] turbo_mask(input zx_pkg::turbo_e t);
		case (t)
			zx_pkg::TURBO_7M:  turbo_mask = 5'b01111;
			zx_pkg::TURBO_14M: turbo_mask = 5'b00111;
			zx_pkg::TURBO_28M: turbo_mask = 5'b00011;
			zx_pkg::TURBO_56M: turbo_mask = 5'b00001;
			default:           turbo_mask = 5'b11111;
		endcase
	endfunction

	assign mask  = turbo_mask(turbo);
	assign phase = counter[4:0] & mask;

	// ========================================
	// Divider and phase enables
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			counter <= '0;
			tick_p  <= 1'b0;
			tick_n  <= 1'b0;
			ce_psg  <= 1'b0;
		end else begin
			counter <= counter + 1'b1;
			tick_p  <= (phase == 5'd0);
			tick_n  <= (phase == (mask ^ {1'b0, mask[4:1]})); // Half period after tick_p
			ce_psg  <= (counter == '0) & ~pause;
		end
	end

	// ========================================
	// CPU enable with turbo change timeout
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			turbo   <= zx_pkg::TURBO_3M5;
			cpu_en  <= 1'b0;
			timeout <= 2'd1;
		end else if (cpu_reset) begin
			cpu_en  <= 1'b0;                   // Restart once reset is released
			timeout <= 2'd1;
		end else if (tick_n) begin
			if (timeout != 2'd0)
				timeout <= timeout + 1'b1;     // 1 -> 2 -> 3 -> 0
			if (turbo != turbo_key) begin
				cpu_en  <= 1'b0;
				timeout <= 2'd1;
				turbo   <= turbo_key;
			end else if (!cpu_en && timeout == 2'd0) begin
				cpu_en <= ~pause;
			end else if (cpu_en && pause) begin
				cpu_en <= 1'b0;
			end
		end
	end

	assign ce_cpu_p = cpu_en & tick_p;
	assign ce_cpu_n = cpu_en & tick_n;

endmodule

`default_nettype wire

// ==== zx_pkg.sv ====
// Shared widths, bank numbers and enums for the Spectrum host glue, used by scoped names
`default_nettype none

package zx_pkg;

	// ========================================
	// Bus and memory widths
	// ========================================
	localparam int ADDR_W      = 16;            // Z80 address bus
	localparam int DATA_W      = 8;
	localparam int BANK_ADDR_W = 18;            // 16 x 16 KB banks
	localparam int OFFSET_W    = 14;            // Offset inside a bank
	localparam int BANK_W      = BANK_ADDR_W - OFFSET_W;
	localparam int FN_W        = 11;            // F1..F11

	// ========================================
	// Bank numbers
	// ========================================
	localparam logic [BANK_W-1:0] BANK_ROM0   = 4'd8;  // 128 editor ROM
	localparam logic [BANK_W-1:0] BANK_ROM1   = 4'd9;  // 48 BASIC ROM
	localparam logic [BANK_W-1:0] BANK_SCREEN = 4'd5;  // Fixed at 4000
	localparam logic [BANK_W-1:0] BANK_MID    = 4'd2;  // Fixed at 8000

	// CPU speed choice, mapped to a divider mask in the clocking block
	typedef enum logic [2:0] {
		TURBO_3M5,
		TURBO_7M,
		TURBO_14M,
		TURBO_28M,
		TURBO_56M
	} turbo_e;

	// Machine model, latched while the CPU is held in reset
	typedef enum logic {
		MACHINE_128,
		MACHINE_48
	} machine_e;

endpackage

`default_nettype wire
